//--- logic/softmax_pkg.sv
// Shared widths, stream beat types and the issue FSM encoding for the
// softmax normalization block. Every RTL file refers to these by
// scoped name, so a width change here reaches the whole datapath.

package softmax_pkg;

  // ========================================
  // Widths
  // ========================================

  // Attention coefficient, exponent is 2^coef
  localparam int COEF_WIDTH  = 5;
  // Largest exponent is 2^31
  localparam int EXP_WIDTH   = 32;
  localparam int MAX_NODES   = 16;
  // Room for MAX_NODES exponents of full size
  localparam int SUM_WIDTH   = EXP_WIDTH + $clog2(MAX_NODES);
  // Q1.31 weight
  localparam int ALPHA_WIDTH = 32;
  // Input register plus one stage per quotient bit
  localparam int DIV_LATENCY = ALPHA_WIDTH + 1;

  // ========================================
  // Stream beats
  // ========================================

  typedef struct packed {
    logic [COEF_WIDTH-1:0] coef;
    logic                  last;
  } coef_beat_t;

  typedef struct packed {
    logic [EXP_WIDTH-1:0] value;
    logic                 last;
  } exp_beat_t;

  typedef struct packed {
    logic [ALPHA_WIDTH-1:0] alpha;
    logic                   last;
  } alpha_beat_t;

  // Divider issue FSM
  typedef enum logic {
    ST_LOAD,
    ST_RUN
  } issue_state_t;

endpackage

//--- logic/sync_fifo.sv
// Synchronous FIFO with first-word fall-through output.
// The head entry is always visible on dout while empty is low.
// Writes when full and reads when empty are dropped.

`timescale 1ns/100ps

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [WIDTH-1:0] din,
  input  logic             wr,
  output logic             full,
  output logic [WIDTH-1:0] dout,
  input  logic             rd,
  output logic             empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [0:DEPTH-1];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             wr_en;
  logic             rd_en;

  assign wr_en = wr && !full;
  assign rd_en = rd && !empty;
  assign full  = (count == CNT_W'(DEPTH));
  assign empty = (count == '0);
  assign dout  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= din;
    end
  end

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- logic/exp_sum_acc.sv
// Input side of the softmax block. Accepts coefficient beats, turns each
// into its base-2 exponent and pushes it to the dividend FIFO in the
// transfer cycle. The running group sum goes to the divisor FIFO one
// cycle after the last beat of the group.

`timescale 1ns/100ps

module exp_sum_acc (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  softmax_pkg::coef_beat_t               coef_in,
  input  logic                                  coef_valid,
  output logic                                  coef_ready,
  input  logic                                  divd_full,
  input  logic                                  dvsr_full,
  output logic                                  divd_wr,
  output logic                                  dvsr_wr,
  output softmax_pkg::exp_beat_t                divd_din,
  output logic [softmax_pkg::SUM_WIDTH-1:0]     dvsr_din
);

  localparam int EW = softmax_pkg::EXP_WIDTH;
  localparam int SW = softmax_pkg::SUM_WIDTH;

  logic          xfer;
  logic [EW-1:0] exp_val;
  logic [SW-1:0] sum_r;
  logic [SW-1:0] sum_nxt;
  logic          first_r;

  // ========================================
  // Handshake
  // ========================================

  // A last beat also needs a divisor slot. The sum write trails the
  // beat by a cycle, so a pending write counts as a taken slot
  assign coef_ready = !divd_full && !(coef_in.last && (dvsr_full || dvsr_wr));
  assign xfer       = coef_valid && coef_ready;

  // ========================================
  // Exponent and running sum
  // ========================================

  assign exp_val = {{(EW-1){1'b0}}, 1'b1} << coef_in.coef;

  // Restart on the first beat of each group
  assign sum_nxt = (first_r ? '0 : sum_r) + {{(SW-EW){1'b0}}, exp_val};

  assign divd_wr        = xfer;
  assign divd_din.value = exp_val;
  assign divd_din.last  = coef_in.last;

  always_ff @(posedge clk) begin
    if (xfer) begin
      sum_r <= sum_nxt;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      first_r <= 1'b1;
      dvsr_wr <= 1'b0;
    end else begin
      if (xfer) begin
        first_r <= coef_in.last;
      end
      // Completed sum sits in sum_r during this write
      dvsr_wr <= xfer && coef_in.last;
    end
  end

  assign dvsr_din = sum_r;

endmodule

//--- logic/div_issue.sv
// Divider issue control. Loads one group sum from the divisor FIFO,
// then pairs it with that group's exponents from the dividend FIFO,
// one per cycle while the output side grants credit. The last
// exponent of a group sends the FSM back for the next sum.

`timescale 1ns/100ps

module div_issue (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  softmax_pkg::exp_beat_t                divd_dout,
  input  logic                                  divd_empty,
  output logic                                  divd_rd,
  input  logic [softmax_pkg::SUM_WIDTH-1:0]     dvsr_dout,
  input  logic                                  dvsr_empty,
  output logic                                  dvsr_rd,
  input  logic                                  credit_ok,
  output logic                                  div_valid,
  output logic                                  div_last,
  output logic [softmax_pkg::EXP_WIDTH-1:0]     div_dividend,
  output logic [softmax_pkg::SUM_WIDTH-1:0]     div_divisor
);

  softmax_pkg::issue_state_t               state_r;
  logic [softmax_pkg::SUM_WIDTH-1:0]       dvsr_r;

  // FIFO pops
  assign dvsr_rd = (state_r == softmax_pkg::ST_LOAD) && !dvsr_empty;
  assign divd_rd = (state_r == softmax_pkg::ST_RUN) && !divd_empty && credit_ok;

  // Divider inputs, registered inside the divider
  assign div_valid    = divd_rd;
  assign div_dividend = divd_dout.value;
  assign div_last     = divd_dout.last;
  assign div_divisor  = dvsr_r;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_r <= softmax_pkg::ST_LOAD;
    end else begin
      case (state_r)
        softmax_pkg::ST_LOAD: begin
          if (dvsr_rd) begin
            state_r <= softmax_pkg::ST_RUN;
          end
        end
        softmax_pkg::ST_RUN: begin
          if (divd_rd && divd_dout.last) begin
            state_r <= softmax_pkg::ST_LOAD;
          end
        end
        default: begin
          state_r <= softmax_pkg::ST_LOAD;
        end
      endcase
    end
  end

  // Group sum held for the whole group
  always_ff @(posedge clk) begin
    if (dvsr_rd) begin
      dvsr_r <= dvsr_dout;
    end
  end

endmodule

//--- logic/fxp_div_pipe.sv
// Pipelined restoring divider giving floor(dividend * 2^31 / divisor)
// as a Q1.31 value. One input register, then one stage per quotient
// bit, MSB first. A new division may enter every cycle and the result
// leaves DIV_LATENCY cycles later with its last tag.

`timescale 1ns/100ps

module fxp_div_pipe (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  div_valid,
  input  logic [softmax_pkg::EXP_WIDTH-1:0]     div_dividend,
  input  logic [softmax_pkg::SUM_WIDTH-1:0]     div_divisor,
  input  logic                                  div_last,
  output logic                                  res_valid,
  output softmax_pkg::alpha_beat_t              res_beat
);

  localparam int QW   = softmax_pkg::ALPHA_WIDTH;
  localparam int SW   = softmax_pkg::SUM_WIDTH;
  localparam int EW   = softmax_pkg::EXP_WIDTH;
  localparam int LAST = softmax_pkg::DIV_LATENCY - 1;

  // Index 0 is the input register
  logic [LAST:0]   vld_sr;
  logic [LAST:0]   last_sr;
  logic [SW-1:0]   rem_r   [0:QW-1];
  logic [SW-1:0]   dvsr_r  [0:QW-1];
  logic [QW-1:0]   quo_r   [1:LAST];
  logic            lsb_r;

  logic [SW:0]     part    [0:QW-1];
  logic [SW-1:0]   rem_nxt [0:QW-2];
  logic [QW-1:0]   take_sub;

  // ========================================
  // Stage arithmetic
  // ========================================

  // Stage 0 shifts in the dividend LSB, which makes its partial
  // remainder the dividend itself and its bit the integer bit
  always_comb begin
    for (int i = 0; i < QW; i++) begin
      part[i]     = {rem_r[i], (i == 0) ? lsb_r : 1'b0};
      take_sub[i] = (part[i] >= {1'b0, dvsr_r[i]});
      if (i < QW - 1) begin
        rem_nxt[i] = take_sub[i] ? SW'(part[i] - {1'b0, dvsr_r[i]}) : SW'(part[i]);
      end
    end
  end

  // ========================================
  // Pipeline registers
  // ========================================

  always_ff @(posedge clk) begin
    rem_r[0]  <= {{(SW-EW+1){1'b0}}, div_dividend[EW-1:1]};
    lsb_r     <= div_dividend[0];
    dvsr_r[0] <= div_divisor;
    for (int i = 1; i < QW; i++) begin
      rem_r[i]  <= rem_nxt[i-1];
      dvsr_r[i] <= dvsr_r[i-1];
    end
    quo_r[1] <= {{(QW-1){1'b0}}, take_sub[0]};
    for (int i = 2; i <= LAST; i++) begin
      quo_r[i] <= {quo_r[i-1][QW-2:0], take_sub[i-1]};
    end
    last_sr <= {last_sr[LAST-1:0], div_last};
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[LAST-1:0], div_valid};
    end
  end

  assign res_valid      = vld_sr[LAST];
  assign res_beat.alpha = quo_r[LAST];
  assign res_beat.last  = last_sr[LAST];

endmodule

//--- logic/alpha_out_buf.sv
// Output side of the softmax block. Buffers divider results and offers
// them as the alpha valid/ready stream. The divider cannot stall, so
// this block hands out issue credit instead: every issue reserves a
// buffer slot until its result leaves through the output handshake.

`timescale 1ns/100ps

module alpha_out_buf #(
  parameter int OUT_DEPTH = 40
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      res_valid,
  input  softmax_pkg::alpha_beat_t  res_beat,
  output softmax_pkg::alpha_beat_t  alpha_out,
  output logic                      alpha_valid,
  input  logic                      alpha_ready,
  output logic                      credit_ok,
  input  logic                      div_valid
);

  localparam int CNT_W = $clog2(OUT_DEPTH + 1);

  logic             out_empty;
  logic             out_xfer;
  logic [CNT_W-1:0] outstanding;

  sync_fifo #(
    .WIDTH ($bits(softmax_pkg::alpha_beat_t)),
    .DEPTH (OUT_DEPTH)
  ) out_fifo_i (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (res_beat),
    .wr    (res_valid),
    .full  (),
    .dout  (alpha_out),
    .rd    (out_xfer),
    .empty (out_empty)
  );

  assign alpha_valid = !out_empty;
  assign out_xfer    = alpha_valid && alpha_ready;

  // In flight plus stored, never above OUT_DEPTH
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= '0;
    end else if (div_valid && !out_xfer) begin
      outstanding <= outstanding + 1'b1;
    end else if (out_xfer && !div_valid) begin
      outstanding <= outstanding - 1'b1;
    end
  end

  assign credit_ok = (outstanding < CNT_W'(OUT_DEPTH));

endmodule

//--- logic/softmax.sv
// Top level of the softmax normalization block.
// Coefficient beats in, one Q1.31 weight per coefficient out, both
// as valid/ready streams with a last flag marking the end of a group.
// Buffer depths are set here and passed down.

`timescale 1ns/100ps

module softmax #(
  parameter int DIVD_DEPTH = 32,
  parameter int DVSR_DEPTH = 4,
  parameter int OUT_DEPTH  = 40
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  softmax_pkg::coef_beat_t   coef_in,
  input  logic                      coef_valid,
  output logic                      coef_ready,
  output softmax_pkg::alpha_beat_t  alpha_out,
  output logic                      alpha_valid,
  input  logic                      alpha_ready
);

  softmax_pkg::exp_beat_t                divd_din;
  softmax_pkg::exp_beat_t                divd_dout;
  logic                                  divd_wr;
  logic                                  divd_rd;
  logic                                  divd_full;
  logic                                  divd_empty;

  logic [softmax_pkg::SUM_WIDTH-1:0]     dvsr_din;
  logic [softmax_pkg::SUM_WIDTH-1:0]     dvsr_dout;
  logic                                  dvsr_wr;
  logic                                  dvsr_rd;
  logic                                  dvsr_full;
  logic                                  dvsr_empty;

  logic                                  credit_ok;
  logic                                  div_valid;
  logic                                  div_last;
  logic [softmax_pkg::EXP_WIDTH-1:0]     div_dividend;
  logic [softmax_pkg::SUM_WIDTH-1:0]     div_divisor;
  logic                                  res_valid;
  softmax_pkg::alpha_beat_t              res_beat;

  // ========================================
  // Input side and buffers
  // ========================================

  exp_sum_acc exp_sum_acc_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .coef_in    (coef_in),
    .coef_valid (coef_valid),
    .coef_ready (coef_ready),
    .divd_full  (divd_full),
    .dvsr_full  (dvsr_full),
    .divd_wr    (divd_wr),
    .dvsr_wr    (dvsr_wr),
    .divd_din   (divd_din),
    .dvsr_din   (dvsr_din)
  );

  sync_fifo #(
    .WIDTH ($bits(softmax_pkg::exp_beat_t)),
    .DEPTH (DIVD_DEPTH)
  ) divd_fifo_i (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (divd_din),
    .wr    (divd_wr),
    .full  (divd_full),
    .dout  (divd_dout),
    .rd    (divd_rd),
    .empty (divd_empty)
  );

  sync_fifo #(
    .WIDTH (softmax_pkg::SUM_WIDTH),
    .DEPTH (DVSR_DEPTH)
  ) dvsr_fifo_i (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (dvsr_din),
    .wr    (dvsr_wr),
    .full  (dvsr_full),
    .dout  (dvsr_dout),
    .rd    (dvsr_rd),
    .empty (dvsr_empty)
  );

  // ========================================
  // Divide and output
  // ========================================

  div_issue div_issue_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .divd_dout    (divd_dout),
    .divd_empty   (divd_empty),
    .divd_rd      (divd_rd),
    .dvsr_dout    (dvsr_dout),
    .dvsr_empty   (dvsr_empty),
    .dvsr_rd      (dvsr_rd),
    .credit_ok    (credit_ok),
    .div_valid    (div_valid),
    .div_last     (div_last),
    .div_dividend (div_dividend),
    .div_divisor  (div_divisor)
  );

  fxp_div_pipe fxp_div_pipe_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .div_valid    (div_valid),
    .div_dividend (div_dividend),
    .div_divisor  (div_divisor),
    .div_last     (div_last),
    .res_valid    (res_valid),
    .res_beat     (res_beat)
  );

  alpha_out_buf #(
    .OUT_DEPTH (OUT_DEPTH)
  ) alpha_out_buf_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .res_valid   (res_valid),
    .res_beat    (res_beat),
    .alpha_out   (alpha_out),
    .alpha_valid (alpha_valid),
    .alpha_ready (alpha_ready),
    .credit_ok   (credit_ok),
    .div_valid   (div_valid)
  );

endmodule

//--- bench/softmax_chk.sv
// Handshake assertions for the softmax top level.
// Bound into every softmax instance, watches the output stream and
// the input ready around reset.

`timescale 1ns/100ps

module softmax_chk (
  input logic                     clk,
  input logic                     rst_n,
  input softmax_pkg::alpha_beat_t alpha_out,
  input logic                     alpha_valid,
  input logic                     alpha_ready,
  input logic                     coef_ready
);

  // Stalled beat holds its value
  out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    alpha_valid && !alpha_ready |=> alpha_valid && $stable(alpha_out))
    else $error("alpha_out changed while stalled");

  out_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !alpha_valid)
    else $error("alpha_valid high during reset");

  ready_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> coef_ready)
    else $error("coef_ready low in first cycle after reset");

endmodule

bind softmax softmax_chk softmax_chk_i (
  .clk         (clk),
  .rst_n       (rst_n),
  .alpha_out   (alpha_out),
  .alpha_valid (alpha_valid),
  .alpha_ready (alpha_ready),
  .coef_ready  (coef_ready)
);

//--- bench/softmax_tb.sv
// Testbench for the softmax normalization block.
// Applies a table of coefficient groups, collects the weights and compares
// them with floor(2^c * 2^31 / sum of 2^c) computed here per group.
// Random groups at the end of the table also get random alpha_ready.

`timescale 1ns/100ps

module softmax_tb;

  localparam int MAX_TESTS = 40;
  localparam int N_RANDOM  = 24;
  localparam int QUIET     = softmax_pkg::DIV_LATENCY + 10;

  typedef int coef_list_t [16];

  logic                     clk;
  logic                     rst_n;
  softmax_pkg::coef_beat_t  coef_in;
  logic                     coef_valid;
  logic                     coef_ready;
  softmax_pkg::alpha_beat_t alpha_out;
  logic                     alpha_valid;
  logic                     alpha_ready;

  // Stimulus table
  string      tname [MAX_TESTS];
  int         tlen  [MAX_TESTS];
  coef_list_t tcoef [MAX_TESTS];
  bit         trnd  [MAX_TESTS];
  int         ntests;

  // Expected stream, one entry per coefficient
  logic [softmax_pkg::ALPHA_WIDTH-1:0] exp_alpha [$];
  bit                                  exp_last  [$];
  int                                  exp_test  [$];

  int seed;
  int errors;
  int total;
  int rcv;
  int cycles;
  int limit;

  softmax dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .coef_in     (coef_in),
    .coef_valid  (coef_valid),
    .coef_ready  (coef_ready),
    .alpha_out   (alpha_out),
    .alpha_valid (alpha_valid),
    .alpha_ready (alpha_ready)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // ========================================
  // Run limit
  // ========================================

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("timeout after %0d cycles, %0d of %0d beats received", cycles, rcv, total);
      $display("Something failed");
      $finish;
    end
  end

  task automatic add_test(input string name, input int len, input coef_list_t c,
                          input bit rnd);
    tname[ntests] = name;
    tlen[ntests]  = len;
    tcoef[ntests] = c;
    trnd[ntests]  = rnd;
    ntests++;
  endtask

  task automatic build_table();
    coef_list_t c;
    int         r;
    add_test("single_node", 1, '{7, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0}, 1'b0);
    add_test("equal_n3", 3, '{5, 5, 5, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0}, 1'b0);
    add_test("equal_n16_max", 16,
             '{31, 31, 31, 31, 31, 31, 31, 31, 31, 31, 31, 31, 31, 31, 31, 31}, 1'b0);
    add_test("mixed_0_31", 4, '{0, 31, 3, 17, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0}, 1'b0);
    add_test("mixed_long", 16,
             '{31, 0, 30, 1, 29, 2, 16, 15, 8, 24, 31, 31, 4, 12, 20, 28}, 1'b0);
    add_test("b2b_len2", 2, '{1, 2, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0}, 1'b0);
    add_test("b2b_len16", 16,
             '{3, 9, 27, 14, 0, 31, 6, 6, 11, 19, 22, 5, 1, 30, 13, 7}, 1'b0);
    add_test("b2b_len1", 1, '{9, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0}, 1'b0);
    add_test("b2b_len7", 7, '{10, 10, 11, 0, 31, 25, 2, 0, 0, 0, 0, 0, 0, 0, 0, 0}, 1'b0);
    for (int k = 0; k < N_RANDOM; k++) begin
      for (int j = 0; j < 16; j++) begin
        r = $random(seed);
        c[j] = r & 31;
      end
      r = $random(seed);
      add_test($sformatf("random_%0d", k), 1 + (r & 15), c, 1'b1);
    end
  endtask

  // Reference rule straight from the weight definition
  task automatic build_expected();
    logic [63:0] sum;
    logic [63:0] q;
    for (int t = 0; t < ntests; t++) begin
      sum = '0;
      for (int j = 0; j < tlen[t]; j++) begin
        sum = sum + (64'd1 << tcoef[t][j]);
      end
      for (int j = 0; j < tlen[t]; j++) begin
        q = (64'd1 << (tcoef[t][j] + 31)) / sum;
        exp_alpha.push_back(q[softmax_pkg::ALPHA_WIDTH-1:0]);
        exp_last.push_back(j == tlen[t] - 1);
        exp_test.push_back(t);
      end
    end
    total = exp_alpha.size();
  endtask

  // ========================================
  // Input and output processes
  // ========================================

  task automatic check_idle(input int n);
    repeat (n) begin
      @(negedge clk);
      #1;
      if (alpha_valid) begin
        errors++;
        $display("output valid after reset before any input was given");
      end
      if (!coef_ready) begin
        errors++;
        $display("coef_ready is low after reset with nothing in flight");
      end
    end
  endtask

  task automatic drive_all();
    bit acc;
    for (int t = 0; t < ntests; t++) begin
      for (int j = 0; j < tlen[t]; j++) begin
        @(negedge clk);
        coef_valid    = 1'b1;
        coef_in.coef  = tcoef[t][j][softmax_pkg::COEF_WIDTH-1:0];
        coef_in.last  = (j == tlen[t] - 1);
        acc = 1'b0;
        while (!acc) begin
          #1;
          acc = coef_ready;
          @(posedge clk);
          if (!acc) begin
            @(negedge clk);
          end
        end
      end
    end
    @(negedge clk);
    coef_valid = 1'b0;
  endtask

  task automatic collect_all();
    softmax_pkg::alpha_beat_t beat;
    bit                       got;
    int                       r;
    int                       t;
    while (rcv < total) begin
      @(negedge clk);
      r = $random(seed);
      alpha_ready = trnd[exp_test[rcv]] ? r[0] : 1'b1;
      #1;
      got  = alpha_valid && alpha_ready;
      beat = alpha_out;
      @(posedge clk);
      if (got) begin
        t = exp_test[rcv];
        if (beat.alpha !== exp_alpha[rcv]) begin
          errors++;
          $display("error %s beat %0d: alpha expected %h actual %h",
                   tname[t], rcv, exp_alpha[rcv], beat.alpha);
        end
        if (beat.last !== exp_last[rcv]) begin
          errors++;
          $display("error %s beat %0d: last expected %b actual %b",
                   tname[t], rcv, exp_last[rcv], beat.last);
        end
        rcv++;
      end
    end
    // Nothing more may come out
    @(negedge clk);
    alpha_ready = 1'b1;
    repeat (QUIET) begin
      #1;
      if (alpha_valid) begin
        errors++;
        $display("extra output beat after all %0d expected beats", total);
      end
      @(negedge clk);
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    coef_in     = '0;
    coef_valid  = 1'b0;
    alpha_ready = 1'b0;
    seed        = 32'hd762;
    errors      = 0;
    rcv         = 0;
    cycles      = 0;
    ntests      = 0;
    build_table();
    build_expected();
    limit = 4 * total + softmax_pkg::DIV_LATENCY + 200;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    check_idle(10);
    fork
      drive_all();
      collect_all();
    join
    $display("errors: %0d, beats received: %0d of %0d", errors, rcv, total);
    if (errors == 0 && rcv == total) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- softmax.f
logic/softmax_pkg.sv
logic/sync_fifo.sv
logic/exp_sum_acc.sv
logic/div_issue.sv
logic/fxp_div_pipe.sv
logic/alpha_out_buf.sv
logic/softmax.sv
bench/softmax_chk.sv
bench/softmax_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module softmax_tb -f softmax.f -o softmax_sim

out=$(./obj_dir/softmax_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1
